/* include/xt_tb_tasks.svh */
// Bus-cycle driver tasks and directed tests for the XT peripheral testbench
// Included inside the testbench module, uses its signals and model state

`ifndef XT_TB_TASKS_SVH
`define XT_TB_TASKS_SVH

// Strobes high, address parked outside every EMS window
task automatic drive_idle();
    bus.address          = '0;
    bus.data             = BUS_IDLE_DATA;
    bus.io_read_n        = 1'b1;
    bus.io_write_n       = 1'b1;
    bus.memory_read_n    = 1'b1;
    bus.address_enable_n = 1'b1;
endtask

task automatic next_cycle();
    @(posedge clock);
    #1;
endtask

task automatic check_value(input string name, input cpu_data_t actual, input cpu_data_t expected);
    check_count++;
    assert (actual === expected)
    else begin
        $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        error_count++;
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    check_value(name, {7'h00, actual}, {7'h00, expected});
endtask

task automatic finish_test(input string name);
    test_count++;
    $display("%s: %0d checks, %0d errors", name,
             check_count - checks_at_start, error_count - errors_at_start);
    checks_at_start = check_count;
    errors_at_start = error_count;
endtask

// Write cycle plus one idle clock, so the EMS pipeline has drained
task automatic io_write(input logic [15:0] port, input cpu_data_t value);
    bus.address          = {4'h0, port};
    bus.data             = value;
    bus.io_write_n       = 1'b0;
    bus.address_enable_n = 1'b0;
    next_cycle();
    drive_idle();
    next_cycle();
endtask

// Result taken one clock later, once the read mux has registered it
task automatic io_read(input logic [15:0] port, output cpu_data_t value, output logic chipset);
    bus.address          = {4'h0, port};
    bus.io_read_n        = 1'b0;
    bus.address_enable_n = 1'b0;
    next_cycle();
    value   = data;
    chipset = from_chipset;
    drive_idle();
endtask

task automatic read_expect(input logic [15:0] port, input cpu_data_t expected,
                           input logic chipset_expected);
    cpu_data_t value;
    logic      chipset;
    io_read(port, value, chipset);
    check_value($sformatf("data_o from port %h", port), value, expected);
    check_bit($sformatf("from_chipset_o from port %h", port), chipset, chipset_expected);
endtask

// EMS slot rules: FFh disables, below 80h maps and enables, the rest is ignored
function automatic void ems_model_write(input ems_slot_t slot, input cpu_data_t value);
    if (value == 8'hFF) begin
        ems_page_model[slot]   = 7'h7F;
        ems_enable_model[slot] = 1'b0;
    end else if (value < 8'h80) begin
        ems_page_model[slot]   = value[6:0];
        ems_enable_model[slot] = 1'b1;
    end
endfunction

function automatic cpu_data_t ems_model_read(input ems_slot_t slot);
    return ems_enable_model[slot] ? {1'b0, ems_page_model[slot]} : 8'hFF;
endfunction

task automatic ems_write(input ems_slot_t slot, input cpu_data_t value);
    io_write(EMS_PORT_BASE | {14'h0, slot}, value);
    ems_model_write(slot, value);
endtask

task automatic ems_read_all();
    for (int s = 0; s < 4; s++) begin
        read_expect(EMS_PORT_BASE | 16'(s), ems_model_read(2'(s)), 1'b1);
    end
endtask

// Memory cycle, bank hits are checked while the address is on the bus
task automatic memory_cycle(input logic [19:0] address, input logic [3:0] expected);
    bus.address          = address;
    bus.memory_read_n    = 1'b0;
    bus.address_enable_n = 1'b0;
    #1;
    check_value($sformatf("ems_bank_hit_o at %h", address), {4'h0, bank_hit}, {4'h0, expected});
    next_cycle();
    drive_idle();
endtask

// DMA selects follow the strobe, address left on the bus after release
task automatic decode_check(input logic [15:0] port, input logic write,
                            input logic dma_n_expected, input logic page_n_expected);
    bus.address          = {4'h0, port};
    bus.address_enable_n = 1'b0;
    if (write) begin
        bus.io_write_n = 1'b0;
    end else begin
        bus.io_read_n = 1'b0;
    end
    #1;
    check_bit($sformatf("dma_cs_n_o at port %h", port), dma_cs_n, dma_n_expected);
    check_bit($sformatf("dma_page_cs_n_o at port %h", port), dma_page_cs_n, page_n_expected);
    bus.io_read_n  = 1'b1;
    bus.io_write_n = 1'b1;
    #1;
    check_bit($sformatf("dma_cs_n_o idle at port %h", port), dma_cs_n, 1'b1);
    check_bit($sformatf("dma_page_cs_n_o idle at port %h", port), dma_page_cs_n, 1'b1);
    next_cycle();
    drive_idle();
endtask

task automatic count_step(inout logic last, inout int toggles);
    next_cycle();
    if (timer_clock !== last) begin
        toggles++;
    end
    last = timer_clock;
endtask

task automatic reset_state_test();
    check_bit("from_chipset_o", from_chipset, 1'b0);
    check_bit("dma_cs_n_o", dma_cs_n, 1'b1);
    check_bit("dma_page_cs_n_o", dma_page_cs_n, 1'b1);
    check_value("tandy_page_o", tandy_page, 8'h00);
    check_bit("timer_clock_o", timer_clock, 1'b0);
    // Every block of the A000 frame stays quiet with all slots disabled
    for (int s = 0; s < 4; s++) begin
        memory_cycle({4'hA, 2'(s), 14'($urandom)}, 4'h0);
    end
    tandy_video = 1'b1;
    read_expect(LPT_PORT, 8'hFF, 1'b1);
    read_expect(NMI_MASK_BASE, 8'hFF, 1'b1);
    finish_test("reset state");
endtask

task automatic latch_test();
    cpu_data_t value;
    tandy_video = 1'b1;
    for (int i = 0; i < 8; i++) begin
        value = 8'($urandom);
        io_write(LPT_PORT, value);
        lpt_model = value;
        read_expect(LPT_PORT, lpt_model, 1'b1);
        // Any port of the A0h-A7h block reaches the mask
        value = 8'($urandom);
        io_write(NMI_MASK_BASE | 16'(i), value);
        nmi_model = value;
        read_expect(NMI_MASK_BASE, nmi_model, 1'b1);
        value = 8'($urandom);
        io_write(TANDY_PAGE_PORT, value);
        tandy_model = value;
        check_value("tandy_page_o", tandy_page, tandy_model);
    end
    // Mask port not decoded without Tandy video
    tandy_video = 1'b0;
    io_write(NMI_MASK_BASE, ~nmi_model);
    read_expect(NMI_MASK_BASE, 8'h00, 1'b0);
    tandy_video = 1'b1;
    read_expect(NMI_MASK_BASE, nmi_model, 1'b1);
    finish_test("board latches");
endtask

task automatic ems_map_test();
    ems_enabled = 1'b1;
    for (int s = 0; s < 4; s++) begin
        ems_write(2'(s), 8'($urandom % 128));
    end
    ems_read_all();
    // 80h-FEh leave every slot alone
    for (int s = 0; s < 4; s++) begin
        ems_write(2'(s), 8'(128 + $urandom % 127));
    end
    ems_read_all();
    ems_write(2'd1, 8'hFF);
    ems_write(2'd3, 8'hFF);
    ems_read_all();
    for (int s = 0; s < 4; s++) begin
        ems_write(2'(s), 8'(128 + $urandom % 127));
    end
    ems_read_all();
    ems_write(2'd3, 8'($urandom % 128));
    ems_read_all();
    // Ports 260h-263h vanish with EMS off, writes included
    ems_enabled = 1'b0;
    read_expect(EMS_PORT_BASE, 8'h00, 1'b0);
    io_write(EMS_PORT_BASE, 8'hFF);
    ems_enabled = 1'b1;
    ems_read_all();
    finish_test("ems map");
endtask

task automatic bank_hit_test();
    logic [3:0] base;
    logic [3:0] expected;
    ems_enabled = 1'b1;
    for (int w = 0; w < 4; w++) begin
        ems_window = 2'(w);
        // Setting 3 shares the D000 frame
        base = (w == 0) ? 4'hA : (w == 1) ? 4'hC : 4'hD;
        for (int s = 0; s < 4; s++) begin
            ems_write(2'(s), ((s + w) % 2 == 0) ? 8'($urandom % 128) : 8'hFF);
        end
        for (int s = 0; s < 4; s++) begin
            expected = ems_enable_model[s] ? 4'(1 << s) : 4'h0;
            memory_cycle({base, 2'(s), 14'($urandom)}, expected);
        end
        // B000 is never an EMS frame
        memory_cycle({4'hB, 16'($urandom)}, 4'h0);
    end
    finish_test("ems bank hits");
endtask

task automatic dma_select_test();
    for (int i = 0; i < 6; i++) begin
        decode_check(16'($urandom % 32), (i % 2) == 1, 1'b0, 1'b1);
        decode_check(16'(128 + $urandom % 32), (i % 2) == 1, 1'b1, 1'b0);
    end
    // Neighbours of both ranges
    decode_check(16'h0020, 1'b0, 1'b1, 1'b1);
    decode_check(16'h007F, 1'b1, 1'b1, 1'b1);
    decode_check(16'h00A0, 1'b0, 1'b1, 1'b1);
    decode_check(LPT_PORT, 1'b0, 1'b1, 1'b1);
    finish_test("dma selects");
endtask

task automatic timer_clock_test();
    int   edges;
    int   toggles;
    logic last;
    edges   = 6 + int'($urandom % 5);
    toggles = 0;
    last    = timer_clock;
    for (int e = 0; e < edges; e++) begin
        peripheral_clock = 1'b1;
        repeat (2 + $urandom % 3) count_step(last, toggles);
        peripheral_clock = 1'b0;
        repeat (2 + $urandom % 3) count_step(last, toggles);
    end
    // Synchronizer and toggle flop settle
    repeat (3) count_step(last, toggles);
    check_value("timer_clock_o toggle count", 8'(toggles), 8'(edges));
    finish_test("timer clock");
endtask

`endif

/* dv/xt_periph_tb.sv */
// Testbench for the XT peripheral glue
// Clock, reset, DUT, watchdog, reference model state and result summary

module xt_periph_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import xt_periph_pkg::*;

    localparam int CLOCK_PERIOD = 4;

    // Cycle budgets per test, each above its worst case
    localparam int RESET_BUDGET  = 20;
    localparam int LATCH_BUDGET  = 150;
    localparam int EMS_BUDGET    = 200;
    localparam int WINDOW_BUDGET = 120;
    localparam int DMA_BUDGET    = 60;
    localparam int TIMER_BUDGET  = 150;
    localparam int MARGIN_NS     = 200;
    localparam int WATCHDOG_NS   = (RESET_BUDGET + LATCH_BUDGET + EMS_BUDGET + WINDOW_BUDGET
                                    + DMA_BUDGET + TIMER_BUDGET) * CLOCK_PERIOD + MARGIN_NS;

    logic       clock;
    logic       reset;
    cpu_bus_t   bus;
    logic       ems_enabled;
    logic [1:0] ems_window;
    logic       tandy_video;
    logic       peripheral_clock;
    cpu_data_t  data;
    logic       from_chipset;
    logic       dma_cs_n;
    logic       dma_page_cs_n;
    logic [3:0] bank_hit;
    cpu_data_t  tandy_page;
    logic       timer_clock;

    // Reference model of the board registers and EMS slots
    cpu_data_t  lpt_model;
    cpu_data_t  nmi_model;
    cpu_data_t  tandy_model;
    ems_page_t  ems_page_model [4];
    logic [3:0] ems_enable_model;

    int check_count;
    int error_count;
    int test_count;
    int checks_at_start;
    int errors_at_start;

    xt_peripherals uut (
        .clock              (clock),
        .reset              (reset),
        .bus_i              (bus),
        .ems_enabled_i      (ems_enabled),
        .ems_window_i       (ems_window),
        .tandy_video_i      (tandy_video),
        .peripheral_clock_i (peripheral_clock),
        .data_o             (data),
        .from_chipset_o     (from_chipset),
        .dma_cs_n_o         (dma_cs_n),
        .dma_page_cs_n_o    (dma_page_cs_n),
        .ems_bank_hit_o     (bank_hit),
        .tandy_page_o       (tandy_page),
        .timer_clock_o      (timer_clock)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    `include "xt_tb_tasks.svh"

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a test did not finish", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        ems_enabled      = 1'b0;
        ems_window       = 2'd0;
        tandy_video      = 1'b0;
        peripheral_clock = 1'b0;
        drive_idle();
        check_count     = 0;
        error_count     = 0;
        test_count      = 0;
        checks_at_start = 0;
        errors_at_start = 0;

        // Model starts from the reset values
        lpt_model        = 8'hFF;
        nmi_model        = 8'hFF;
        tandy_model      = 8'h00;
        ems_enable_model = 4'h0;
        for (int s = 0; s < 4; s++) begin
            ems_page_model[s] = 7'h7F;
        end
        void'($urandom(38));

        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        reset_state_test();
        latch_test();
        ems_map_test();
        bank_hit_test();
        dma_select_test();
        timer_clock_test();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the XT peripheral testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
    --top-module xt_periph_tb -o xt_periph_sim > build.log 2>&1 \
    && ./obj_dir/xt_periph_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* source/board_registers.sv */
// Board latches
// Printer data, Tandy page register and NMI mask register

module board_registers (
    input  logic                      clock,
    input  logic                      reset,
    input  xt_periph_pkg::cpu_bus_t   bus_i,
    input  xt_periph_pkg::io_select_t select_i,
    output xt_periph_pkg::cpu_data_t  lpt_data_o,
    output xt_periph_pkg::cpu_data_t  tandy_page_o,
    output xt_periph_pkg::cpu_data_t  nmi_mask_o
);
    import xt_periph_pkg::*;

    logic io_write;

    assign io_write = ~bus_i.io_write_n;

    // Each latch loads the data byte on a write to its port
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o   <= LPT_RESET;
            tandy_page_o <= TANDY_PAGE_RESET;
            nmi_mask_o   <= NMI_MASK_RESET;
        end else begin
            if (io_write & select_i.lpt) begin
                lpt_data_o <= bus_i.data;
            end

            // Page bits select the CPU and video banks of the Tandy memory
            if (io_write & select_i.tandy_page) begin
                tandy_page_o <= bus_i.data;
            end

            if (io_write & select_i.nmi_mask) begin
                nmi_mask_o <= bus_i.data;
            end
        end
    end

endmodule

/* source/ems_mapper.sv */
// EMS page mapper with four slots
// Two-stage write path, slot read-back value and memory window hits

module ems_mapper (
    input  logic                     clock,
    input  logic                     reset,
    input  xt_periph_pkg::cpu_bus_t  bus_i,
    input  logic                     ems_select_i,
    input  logic [1:0]               window_i,
    output xt_periph_pkg::cpu_data_t read_data_o,
    output logic [3:0]               bank_hit_o
);
    import xt_periph_pkg::*;

    logic       write_now;
    logic       code_disable;
    logic       code_map;
    logic       write_accept;
    logic       write_en_q;
    ems_slot_t  write_slot_q;
    ems_page_t  write_page_q;
    logic       write_ena_q;
    ems_page_t  map_q [4];
    logic [3:0] enable_q;
    ems_slot_t  read_slot;
    logic       io_cycle;
    logic [3:0] window_base;

    assign write_now    = ems_select_i & ~bus_i.io_write_n;
    assign code_disable = (bus_i.data == EMS_DISABLE_CODE);
    assign code_map     = (bus_i.data < EMS_MAP_LIMIT);

    // Bytes from 80h to FEh leave the slot alone
    assign write_accept = write_now & (code_disable | code_map);

    // First stage, slot and write enable
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_en_q   <= 1'b0;
            write_slot_q <= '0;
        end else begin
            write_en_q <= write_accept;
            if (write_accept) begin
                write_slot_q <= bus_i.address[1:0];
            end
        end
    end

    // First stage, decoded page and enable bit
    always_ff @(posedge clock) begin
        if (write_accept) begin
            write_page_q <= code_disable ? '1 : bus_i.data[6:0];
            write_ena_q  <= ~code_disable;
        end
    end

    // Second stage, map update
    always_ff @(posedge clock) begin
        if (write_en_q) begin
            map_q[write_slot_q] <= write_page_q;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            enable_q <= '0;
        end else if (write_en_q) begin
            enable_q[write_slot_q] <= write_ena_q;
        end
    end

    // Read-back of the addressed slot
    assign read_slot   = bus_i.address[1:0];
    assign read_data_o = enable_q[read_slot] ? {1'b0, map_q[read_slot]} : BUS_IDLE_DATA;

    // Top nibble of the page frame
    always_comb begin
        case (ems_window_e'(window_i))
            EMS_WINDOW_A000: window_base = 4'hA;
            EMS_WINDOW_C000: window_base = 4'hC;
            default:         window_base = 4'hD;
        endcase
    end

    // Memory cycle whenever no io strobe is active
    assign io_cycle = ~bus_i.io_read_n | ~bus_i.io_write_n;

    // One 16 KB block per slot
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            bank_hit_o[n] = ~io_cycle & enable_q[n]
                          & (bus_i.address[19:14] == {window_base, 2'(n)});
        end
    end

    // Slot in flight moves only together with a queued write
    assert property (@(posedge clock) disable iff (reset)
        !$stable(write_slot_q) |-> write_en_q)
        else $error("ems_mapper: write slot changed without a write");

endmodule

/* source/io_decoder.sv */
// Port address decoder
// Turns the CPU bus into one active-high select per register block

module io_decoder (
    input  xt_periph_pkg::cpu_bus_t   bus_i,
    input  logic                      ems_enabled_i,
    input  logic                      tandy_video_i,
    output xt_periph_pkg::io_select_t select_o
);
    import xt_periph_pkg::*;

    logic        port_cycle;
    logic [15:0] port;

    // Port access only with AEN low and an io strobe active
    assign port_cycle = ~bus_i.address_enable_n & (~bus_i.io_read_n | ~bus_i.io_write_n);
    assign port       = bus_i.address[15:0];

    always_comb begin
        select_o = '0;

        if (port_cycle) begin
            // Motherboard chips decode ten address lines only
            // 000h-01Fh for the DMA controller
            select_o.dma      = (port[9:5] == 5'b00000);
            // 080h-09Fh for the DMA page registers
            select_o.dma_page = (port[9:5] == 5'b00100);

            // Four EMS map ports at 260h-263h
            select_o.ems = ems_enabled_i & (port[15:2] == EMS_PORT_BASE[15:2]);

            select_o.lpt        = (port == LPT_PORT);
            select_o.tandy_page = (port == TANDY_PAGE_PORT);

            // NMI mask at A0h-A7h exists on the Tandy board only
            select_o.nmi_mask = tandy_video_i & (port[15:3] == NMI_MASK_BASE[15:3]);
        end

        // Port ranges do not overlap
        assert ($onehot0(select_o))
            else $error("io_decoder: more than one select active, port %h", port);
    end

endmodule

/* source/read_mux.sv */
// CPU read-back multiplexer
// Registered priority select of the EMS, printer and NMI mask bytes

module read_mux (
    input  logic                      clock,
    input  logic                      reset,
    input  xt_periph_pkg::cpu_bus_t   bus_i,
    input  xt_periph_pkg::io_select_t select_i,
    input  xt_periph_pkg::cpu_data_t  ems_data_i,
    input  xt_periph_pkg::cpu_data_t  lpt_data_i,
    input  xt_periph_pkg::cpu_data_t  nmi_mask_i,
    output xt_periph_pkg::cpu_data_t  data_o,
    output logic                      from_chipset_o
);
    import xt_periph_pkg::*;

    logic io_read;

    assign io_read = ~bus_i.io_read_n;

    // Priority order ems, lpt, nmi mask
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o         <= '0;
            from_chipset_o <= 1'b0;
        end else if (io_read & select_i.ems) begin
            data_o         <= ems_data_i;
            from_chipset_o <= 1'b1;
        end else if (io_read & select_i.lpt) begin
            data_o         <= lpt_data_i;
            from_chipset_o <= 1'b1;
        end else if (io_read & select_i.nmi_mask) begin
            data_o         <= nmi_mask_i;
            from_chipset_o <= 1'b1;
        end else begin
            // Leave the bus to the rest of the system
            data_o         <= '0;
            from_chipset_o <= 1'b0;
        end
    end

    // No read strobe means the chipset releases the bus next clock
    assert property (@(posedge clock) disable iff (reset)
        bus_i.io_read_n |=> !from_chipset_o)
        else $error("read_mux: chipset drives the bus without a read");

endmodule

/* source/timer_clock_gen.sv */
// Timer clock generator
// Peripheral clock synchronizer, rising edge detect and divide by two

module timer_clock_gen (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);
    logic [1:0] sync_q;
    logic       sync_prev_q;
    logic       rise;

    // Two-flop synchronizer plus one flop for the edge detect
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_q      <= '0;
            sync_prev_q <= 1'b0;
        end else begin
            sync_q      <= {sync_q[0], peripheral_clock_i};
            sync_prev_q <= sync_q[1];
        end
    end

    assign rise = sync_q[1] & ~sync_prev_q;

    // Half the peripheral clock rate for the 8253 counters
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            timer_clock_o <= 1'b0;
        end else if (rise) begin
            timer_clock_o <= ~timer_clock_o;
        end
    end

endmodule

/* source/xt_periph_pkg.sv */
// Shared types for the XT peripheral glue
// Bus and select structs, EMS window enum, port addresses and reset values

package xt_periph_pkg;

    // Widths with a meaning on the board
    typedef logic [19:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [6:0]  ems_page_t;
    typedef logic [1:0]  ems_slot_t;

    // CPU side of the bus, strobes active low
    typedef struct packed {
        cpu_addr_t address;
        cpu_data_t data;
        logic      io_read_n;
        logic      io_write_n;
        logic      memory_read_n;
        logic      address_enable_n;
    } cpu_bus_t;

    // Decoded port selects, active high
    typedef struct packed {
        logic dma;
        logic dma_page;
        logic ems;
        logic lpt;
        logic tandy_page;
        logic nmi_mask;
    } io_select_t;

    // EMS frame base, setting 3 falls back to D000
    typedef enum logic [1:0] {
        EMS_WINDOW_A000 = 2'd0,
        EMS_WINDOW_C000 = 2'd1,
        EMS_WINDOW_D000 = 2'd2
    } ems_window_e;

    // Port addresses
    localparam logic [15:0] EMS_PORT_BASE   = 16'h0260;
    localparam logic [15:0] LPT_PORT        = 16'h0378;
    localparam logic [15:0] TANDY_PAGE_PORT = 16'h03DF;
    localparam logic [15:0] NMI_MASK_BASE   = 16'h00A0;

    // Latch values after reset
    localparam cpu_data_t LPT_RESET        = 8'hFF;
    localparam cpu_data_t NMI_MASK_RESET   = 8'hFF;
    localparam cpu_data_t TANDY_PAGE_RESET = 8'h00;

    // Bus values
    localparam cpu_data_t EMS_DISABLE_CODE = 8'hFF;
    localparam cpu_data_t EMS_MAP_LIMIT    = 8'h80;
    localparam cpu_data_t BUS_IDLE_DATA    = 8'hFF;

endpackage

/* source/xt_peripherals.sv */
// Top level of the XT peripheral glue
// Decoder, EMS mapper, board latches, timer clock and read-back mux

module xt_peripherals (
    input  logic                     clock,
    input  logic                     reset,
    input  xt_periph_pkg::cpu_bus_t  bus_i,
    input  logic                     ems_enabled_i,
    input  logic [1:0]               ems_window_i,
    input  logic                     tandy_video_i,
    input  logic                     peripheral_clock_i,
    output xt_periph_pkg::cpu_data_t data_o,
    output logic                     from_chipset_o,
    output logic                     dma_cs_n_o,
    output logic                     dma_page_cs_n_o,
    output logic [3:0]               ems_bank_hit_o,
    output xt_periph_pkg::cpu_data_t tandy_page_o,
    output logic                     timer_clock_o
);
    import xt_periph_pkg::*;

    io_select_t select;
    cpu_data_t  ems_read_data;
    cpu_data_t  lpt_data;
    cpu_data_t  nmi_mask;

    io_decoder u_io_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .tandy_video_i (tandy_video_i),
        .select_o      (select)
    );

    // Chip selects for the external bus arbiter
    assign dma_cs_n_o      = ~select.dma;
    assign dma_page_cs_n_o = ~select.dma_page;

    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .ems_select_i (select.ems),
        .window_i     (ems_window_i),
        .read_data_o  (ems_read_data),
        .bank_hit_o   (ems_bank_hit_o)
    );

    board_registers u_board_registers (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .select_i     (select),
        .lpt_data_o   (lpt_data),
        .tandy_page_o (tandy_page_o),
        .nmi_mask_o   (nmi_mask)
    );

    timer_clock_gen u_timer_clock_gen (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

    read_mux u_read_mux (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus_i),
        .select_i       (select),
        .ems_data_i     (ems_read_data),
        .lpt_data_i     (lpt_data),
        .nmi_mask_i     (nmi_mask),
        .data_o         (data_o),
        .from_chipset_o (from_chipset_o)
    );

endmodule

/* src.f */
+incdir+include
source/xt_periph_pkg.sv
source/io_decoder.sv
source/ems_mapper.sv
source/board_registers.sv
source/timer_clock_gen.sv
source/read_mux.sv
source/xt_peripherals.sv
dv/xt_periph_tb.sv
